// File: verification/lau_sub_unit_vectors.txt
# each line holds gap op a b res borrow zero in hex
# op 0 is SUB 1 is SBB 2 is CMP 3 is NOP and CMP expects the previous res
# gap counts idle cycles before the strobe and f picks 0 to 3 at random
# expected values of NOP lines are ignored
2 0 0005 0003 0002 0 0
0 0 0003 0005 fffe 1 0
0 0 1234 1234 0000 0 1
0 0 0000 0000 0000 0 1
1 0 ffff ffff 0000 0 1
0 0 0000 ffff 0001 1 0
0 0 ffff 0000 ffff 0 0
2 0 0000 0001 ffff 1 0
0 0 8000 7fff 0001 0 0
0 0 7fff 8000 ffff 1 0
# compare keeps res
1 2 0010 0020 ffff 1 0
0 2 0042 0042 ffff 0 1
0 2 0100 0001 ffff 0 0
# 48 bit 000100000000 minus 000000000001
3 0 0000 0001 ffff 1 0
0 1 0000 0000 ffff 1 0
0 1 0001 0000 0000 0 0
# 48 bit equal operands
f 0 9abc 9abc 0000 0 1
0 1 5678 5678 0000 0 1
0 1 1234 1234 0000 0 1
# upper word zero but lower word not
f 0 0005 0003 0002 0 0
0 1 0002 0002 0000 0 0
# negative overall result then NOP inside the chain
1 0 0001 0002 ffff 1 0
0 1 0000 0001 fffe 1 0
0 3 1111 2222 0000 0 0
0 1 0003 0001 0001 0 0
0 2 0005 0007 0001 1 0
0 1 0005 0004 0000 0 0
f 0 00ff 00ff 0000 0 1
f 0 abcd 1234 9999 0 0
f 0 1234 abcd 6667 1 0
2 3 0000 0000 0000 0 0
3 0 4000 4001 ffff 1 0
0 1 ffff ffff ffff 1 0
0 1 ffff fffe 0000 0 0

// File: lau_sub_unit.f
+incdir+include
hdl/lau_pkg.sv
hdl/prefix_and_or.sv
hdl/sub_cz.sv
hdl/lau_sub_unit.sv
verification/lau_sub_unit_props.sv
verification/lau_sub_unit_checker.sv
verification/lau_sub_unit_tb.sv

// File: Makefile
# Verilator build and run of the subtraction unit testbench
# make run SPEED=SLOW|MEDIUM|FAST, or make all_speeds

VERILATOR ?= verilator
TOP ?= lau_sub_unit_tb
FLIST ?= lau_sub_unit.f
SPEED ?= FAST
VFLAGS ?= --binary --timing --assert
OBJ_DIR ?= obj_dir_$(SPEED)
LOG ?= sim_$(SPEED).log

SPEED_NUM_SLOW := 0
SPEED_NUM_MEDIUM := 1
SPEED_NUM_FAST := 2
SPEED_NUM := $(SPEED_NUM_$(SPEED))

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS := $(wildcard include/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run all_speeds clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-Gspeed_sel=$(SPEED_NUM) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "FAIL for speed $(SPEED)"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "FAIL for speed $(SPEED), no pass line"; exit 1; }
	@echo "PASS for speed $(SPEED)"

all_speeds:
	$(MAKE) run SPEED=SLOW
	$(MAKE) run SPEED=MEDIUM
	$(MAKE) run SPEED=FAST

clean:
	rm -rf obj_dir_SLOW obj_dir_MEDIUM obj_dir_FAST sim_*.log

// File: verification/lau_sub_unit_tb.sv
`timescale 1ns/1ps
`include "lau_config.svh"

// testbench top of the subtraction unit
// reads one operation per vector line, drives it and hands the expectation to the checker
module lau_sub_unit_tb import lau_pkg::*; #(
	// prefix variant as a number, 0 SLOW 1 MEDIUM 2 FAST
	parameter int speed_sel = int'(`LAU_SPEED)
);

	localparam int width = `LAU_WIDTH;
	localparam string vector_file = "verification/lau_sub_unit_vectors.txt";
	// cycles allowed for results still in flight after the last strobe
	localparam int drain_limit = 50;
	// guard against a runaway vector file
	localparam int max_lines = 1000;

	logic clk;
	logic rst_n;
	logic op_valid;
	sub_op_e op;
	logic [width-1:0] a;
	logic [width-1:0] b;
	logic res_valid;
	logic [width-1:0] res;
	logic borrow;
	logic zero;

	// seed for the random idle gaps
	integer seed;
	int setup_errors;
	int missing;

	lau_sub_unit #(
		.width(width),
		.speed(speed_e'(speed_sel))
	) u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.op_valid(op_valid),
		.op(op),
		.a(a),
		.b(b),
		.res_valid(res_valid),
		.res(res),
		.borrow(borrow),
		.zero(zero)
	);

	lau_sub_unit_checker #(
		.width(width)
	) u_check (
		.clk(clk),
		.rst_n(rst_n),
		.res_valid(res_valid),
		.res(res),
		.borrow(borrow),
		.zero(zero)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// one cycle with the strobe low
	task automatic drive_idle();
		@(posedge clk);
		#1;
		op_valid = 1'b0;
		op = OP_NOP;
	endtask

	// one strobe, inputs change 1 ns after the edge
	task automatic drive_op(input sub_op_e code, input logic [width-1:0] op_a,
			input logic [width-1:0] op_b);
		@(posedge clk);
		#1;
		op_valid = 1'b1;
		op = code;
		a = op_a;
		b = op_b;
	endtask

	// walk the vector file, one strobe per parsed line
	task automatic run_vectors();
		int fd;
		int fields;
		int line_no;
		int gap_cycles;
		string line_buf;
		logic [31:0] v_gap;
		logic [1:0] v_op;
		logic [width-1:0] v_a;
		logic [width-1:0] v_b;
		logic [width-1:0] v_res;
		logic v_borrow;
		logic v_zero;
		fd = $fopen(vector_file, "r");
		if (fd == 0) begin
			$display("could not open vector file %s", vector_file);
			setup_errors++;
			return;
		end
		line_no = 0;
		while (line_no < max_lines && $fgets(line_buf, fd) != 0) begin
			line_no++;
			fields = $sscanf(line_buf, "%h %h %h %h %h %h %h",
				v_gap, v_op, v_a, v_b, v_res, v_borrow, v_zero);
			// comment and blank lines do not parse
			if (fields == 7) begin
				if (v_gap == 32'hf) begin
					gap_cycles = int'($unsigned($random(seed)) % 32'd4);
				end else begin
					gap_cycles = int'(v_gap);
				end
				repeat (gap_cycles) drive_idle();
				drive_op(sub_op_e'(v_op), v_a, v_b);
				// NOP gives no result, so nothing to expect
				if (sub_op_e'(v_op) != OP_NOP) begin
					u_check.push_expect(v_res, v_borrow, v_zero, line_no);
				end
			end
		end
		$fclose(fd);
		drive_idle();
	endtask

	// wait until the checker has seen every expected result
	task automatic wait_drain(output int left);
		int cycles;
		cycles = 0;
		while (u_check.pending() != 0 && cycles < drain_limit) begin
			@(posedge clk);
			cycles++;
		end
		left = u_check.pending();
	endtask

	initial begin
		seed = 32'h0e87_8eac;
		setup_errors = 0;
		missing = 0;
		clk = 1'b0;
		rst_n = 1'b1;
		op_valid = 1'b0;
		op = OP_NOP;
		a = '0;
		b = '0;
		// clean falling edge so the asynchronous reset fires
		#1;
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// outputs must still hold their reset values before the first strobe
		u_check.check_reset_state();
		run_vectors();
		wait_drain(missing);
		if (missing != 0) begin
			$display("results went missing, %0d operations never produced res_valid", missing);
		end
		// a couple of extra cycles to catch stray res_valid pulses
		repeat (2) @(posedge clk);
		$display("errors: %0d mismatches, %0d unexpected results, %0d missing, %0d setup, %0d assertion",
			u_check.mismatch_count, u_check.unexpected_count, missing, setup_errors,
			u_dut.u_props.fail_count);
		if (u_check.mismatch_count == 0 && u_check.unexpected_count == 0 &&
				missing == 0 && setup_errors == 0 && u_dut.u_props.fail_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: verification/lau_sub_unit_checker.sv
`timescale 1ns/1ps
`include "lau_config.svh"

// result monitor of the subtraction unit
// every res_valid pulse is matched against the oldest pending expectation
module lau_sub_unit_checker #(
	parameter int width = `LAU_WIDTH
) (
	input logic clk,
	input logic rst_n,
	input logic res_valid,
	input logic [width-1:0] res,
	input logic borrow,
	input logic zero
);

	// expectations in issue order, one entry per accepted strobe
	logic [width-1:0] exp_res [$];
	logic exp_borrow [$];
	logic exp_zero [$];
	// vector file line for the error messages
	int exp_line [$];

	int mismatch_count = 0;
	int unexpected_count = 0;

	// queue one expected result
	task automatic push_expect(input logic [width-1:0] r, input logic br, input logic z,
			input int line_no);
		exp_res.push_back(r);
		exp_borrow.push_back(br);
		exp_zero.push_back(z);
		exp_line.push_back(line_no);
	endtask

	// results still owed by the DUT
	function automatic int pending();
		return exp_res.size();
	endfunction

	// idle values after reset: no pulse, res 0, borrow 0, zero 1
	task automatic check_reset_state();
		if (res_valid !== 1'b0 || res !== '0 || borrow !== 1'b0 || zero !== 1'b1) begin
			mismatch_count++;
			$display("Error at %0d ns: after reset res_valid %b res %h borrow %b zero %b",
				$time, res_valid, res, borrow, zero);
		end
	endtask

	// sample on the falling edge, well away from the register updates
	always @(negedge clk) begin : sample
		logic [width-1:0] want_res;
		logic want_borrow;
		logic want_zero;
		int line_no;
		if (rst_n && res_valid) begin
			if (exp_res.size() == 0) begin
				unexpected_count++;
				$display("res_valid at %0d ns without any operation pending", $time);
			end else begin
				want_res = exp_res.pop_front();
				want_borrow = exp_borrow.pop_front();
				want_zero = exp_zero.pop_front();
				line_no = exp_line.pop_front();
				if (res !== want_res) begin
					mismatch_count++;
					$display("Error at %0d ns: line %0d res %h expected %h",
						$time, line_no, res, want_res);
				end
				if (borrow !== want_borrow) begin
					mismatch_count++;
					$display("Error at %0d ns: line %0d borrow %b expected %b",
						$time, line_no, borrow, want_borrow);
				end
				if (zero !== want_zero) begin
					mismatch_count++;
					$display("Error at %0d ns: line %0d zero %b expected %b",
						$time, line_no, zero, want_zero);
				end
			end
		end
	end

endmodule

// File: verification/lau_sub_unit_props.sv
`timescale 1ns/1ps
`include "lau_config.svh"

// concurrent checks on reset values and strobe to result timing
module lau_sub_unit_props import lau_pkg::*; #(
	parameter int width = `LAU_WIDTH
) (
	input logic clk,
	input logic rst_n,
	input logic op_valid,
	input sub_op_e op,
	input logic res_valid,
	input logic [width-1:0] res,
	input logic borrow,
	input logic zero
);

	// failed assertions so far
	int fail_count = 0;

	// held in reset, outputs sit at their idle values
	reset_values: assert property (@(posedge clk)
		!rst_n |-> (!res_valid && res == '0 && !borrow && zero))
		else begin
			$error("outputs not at reset values while rst_n is low");
			fail_count++;
		end

	// each real strobe yields a result one cycle later
	strobe_result: assert property (@(posedge clk) disable iff (!rst_n)
		(op_valid && op != OP_NOP) |=> res_valid)
		else begin
			$error("strobe without res_valid one cycle later");
			fail_count++;
		end

	// no result without a real strobe the cycle before
	result_source: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> $past(op_valid && op != OP_NOP))
		else begin
			$error("res_valid without a matching strobe");
			fail_count++;
		end

	// NOP leaves result and flags alone
	nop_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(op_valid && op == OP_NOP) |=> ($stable(res) && $stable(borrow) && $stable(zero)))
		else begin
			$error("NOP changed res or flags");
			fail_count++;
		end

endmodule

bind lau_sub_unit lau_sub_unit_props #(
	.width(width)
) u_props (
	.clk(clk),
	.rst_n(rst_n),
	.op_valid(op_valid),
	.op(op),
	.res_valid(res_valid),
	.res(res),
	.borrow(borrow),
	.zero(zero)
);

// File: hdl/lau_sub_unit.sv
`timescale 1ns/1ps
`include "lau_config.svh"

// registered multi-word subtraction unit
// one operation per op_valid strobe, result and flags one clock later
// borrow and zero double as chaining state for OP_SBB
module lau_sub_unit import lau_pkg::*; #(
	parameter int width = `LAU_WIDTH,
	parameter speed_e speed = `LAU_SPEED
) (
	input logic clk,
	input logic rst_n,
	// operation strobe, no back-pressure
	input logic op_valid,
	input sub_op_e op,
	input logic [width-1:0] a,
	input logic [width-1:0] b,
	// registered result, valid for one cycle
	output logic res_valid,
	output logic [width-1:0] res,
	output logic borrow,
	output logic zero
);

	// opcode decode
	logic use_borrow;
	logic write_res;
	logic write_flags;

	// subtractor connections
	logic sub_ci;
	logic [width-1:0] diff;
	logic diff_borrow;
	logic diff_zero_raw;

	// flag values to be registered
	logic diff_all_zero;
	logic zero_next;

	// decode of the current opcode, qualified by the strobe
	always_comb begin
		use_borrow = 1'b0;
		write_res = 1'b0;
		write_flags = 1'b0;
		case (op)
			OP_SUB: begin
				write_res = op_valid;
				write_flags = op_valid;
			end
			OP_SBB: begin
				// continue a chain with the borrow of the word below
				use_borrow = 1'b1;
				write_res = op_valid;
				write_flags = op_valid;
			end
			OP_CMP: begin
				// flags only, res keeps the previous difference
				write_flags = op_valid;
			end
			default: begin
				// OP_NOP, nothing moves
				write_flags = 1'b0;
			end
		endcase
	end

	// borrow-in is the stored borrow only when chaining
	assign sub_ci = use_borrow & borrow;

	sub_cz #(
		.width(width),
		.speed(speed)
	) u_sub (
		.a(a),
		.b(b),
		.ci(sub_ci),
		.s(diff),
		.co(diff_borrow),
		.z(diff_zero_raw)
	);

	// explicit zero test, the subtractor flag is wrong once ci can be 1
	assign diff_all_zero = ~|diff;

	// a chained word is zero only if every word so far was zero
	assign zero_next = use_borrow ? (zero & diff_all_zero) : diff_zero_raw;

	// valid pulse, one per accepted operation
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= write_flags;
		end
	end

	// flags and chaining state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			borrow <= 1'b0;
			// empty chain counts as zero
			zero <= 1'b1;
		end else if (write_flags) begin
			borrow <= diff_borrow;
			zero <= zero_next;
		end
	end

	// result register, skipped by OP_CMP and OP_NOP
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res <= '0;
		end else if (write_res) begin
			res <= diff;
		end
	end

endmodule

// File: hdl/sub_cz.sv
`timescale 1ns/1ps
`include "lau_config.svh"

// borrow-lookahead subtractor
// {co, s} = a - b - ci, co set when the result is negative
// z = (s == 0), only meaningful for ci = 0
module sub_cz import lau_pkg::*; #(
	parameter int width = `LAU_WIDTH,
	parameter speed_e speed = `LAU_SPEED
) (
	input logic [width-1:0] a,
	input logic [width-1:0] b,
	input logic ci,
	output logic [width-1:0] s,
	output logic co,
	output logic z
);

	// inverted subtrahend and borrow-in, a - b - ci = a + ~b + ~ci - 2^width
	logic [width-1:0] b_inv;
	logic ci_inv;
	// prefix network inputs and outputs
	logic [width-1:0] gen_in;
	logic [width-1:0] prop_in;
	logic [width-1:0] gen_out;
	logic [width-1:0] prop_out;

	assign b_inv = ~b;
	assign ci_inv = ~ci;

	// bit 0 is a full adder cell, the carry-in joins its generate term
	assign gen_in[0] = (a[0] & b_inv[0]) | (a[0] & ci_inv) | (b_inv[0] & ci_inv);
	assign prop_in[0] = a[0] ^ b_inv[0];

	// remaining bits, plain half adder generate and propagate
	generate
		for (genvar i = 1; i < width; i++) begin : g_pre
			assign gen_in[i] = a[i] & b_inv[i];
			assign prop_in[i] = a[i] ^ b_inv[i];
		end
	endgenerate

	prefix_and_or #(
		.width(width),
		.speed(speed)
	) u_prefix (
		.gi(gen_in),
		.pi(prop_in),
		.go(gen_out),
		.po(prop_out)
	);

	// carry into bit i is the prefix generate of bit i-1, bit 0 sees ~ci
	assign s = prop_in ^ {gen_out[width-2:0], ci_inv};

	// no carry out of the inverted sum means a borrow
	assign co = ~gen_out[width-1];

	// all bits propagating means a == b, so the difference is zero when ci = 0
	assign z = prop_out[width-1];

endmodule

// File: hdl/prefix_and_or.sv
`timescale 1ns/1ps
`include "lau_config.svh"

// parallel-prefix and-or network
// go[i] = gi[i] | pi[i] & gi[i-1] | ... | pi[i] & ... & pi[1] & gi[0]
// po[i] = pi[i] & pi[i-1] & ... & pi[0]
// all three variants compute the same function, only depth and area differ
module prefix_and_or import lau_pkg::*; #(
	parameter int width = `LAU_WIDTH,
	parameter speed_e speed = `LAU_SPEED
) (
	input logic [width-1:0] gi,
	input logic [width-1:0] pi,
	output logic [width-1:0] go,
	output logic [width-1:0] po
);

	// tree depth, one level per power of two
	localparam int levels = $clog2(width);

	generate
		if (speed == SLOW) begin : g_serial
			// ripple chain, width-1 operators in a row
			logic [width-1:0] gc;
			logic [width-1:0] pc;

			assign gc[0] = gi[0];
			assign pc[0] = pi[0];
			for (genvar i = 1; i < width; i++) begin : g_bit
				// extend the prefix of the bit below by one position
				assign gc[i] = gi[i] | (pi[i] & gc[i-1]);
				assign pc[i] = pi[i] & pc[i-1];
			end

			assign go = gc;
			assign po = pc;
		end else if (speed == MEDIUM) begin : g_brent_kung
			// up-sweep stages, gu[0] is the network input
			logic [width-1:0] gu [levels+1];
			logic [width-1:0] pu [levels+1];
			// down-sweep stages, gd[0] is the up-sweep result
			logic [width-1:0] gd [levels];
			logic [width-1:0] pd [levels];

			assign gu[0] = gi;
			assign pu[0] = pi;

			// up-sweep builds spans of 2^(l+1) at the top of each block
			for (genvar l = 0; l < levels; l++) begin : g_up
				for (genvar i = 0; i < width; i++) begin : g_bit
					if ((i + 1) % (2 << l) == 0) begin : g_node
						assign gu[l+1][i] = gu[l][i] | (pu[l][i] & gu[l][i-(1<<l)]);
						assign pu[l+1][i] = pu[l][i] & pu[l][i-(1<<l)];
					end else begin : g_pass
						assign gu[l+1][i] = gu[l][i];
						assign pu[l+1][i] = pu[l][i];
					end
				end
			end

			assign gd[0] = gu[levels];
			assign pd[0] = pu[levels];

			// down-sweep fills the positions in the middle of each block
			// k counts stages, l is the matching span level going down
			for (genvar k = 0; k < levels - 1; k++) begin : g_down
				localparam int l = levels - 2 - k;
				for (genvar i = 0; i < width; i++) begin : g_bit
					if (((i + 1) % (2 << l) == (1 << l)) && (i >= (2 << l))) begin : g_node
						assign gd[k+1][i] = gd[k][i] | (pd[k][i] & gd[k][i-(1<<l)]);
						assign pd[k+1][i] = pd[k][i] & pd[k][i-(1<<l)];
					end else begin : g_pass
						assign gd[k+1][i] = gd[k][i];
						assign pd[k+1][i] = pd[k][i];
					end
				end
			end

			assign go = gd[levels-1];
			assign po = pd[levels-1];
		end else begin : g_sklansky
			// divide and conquer, each level doubles the solved block size
			logic [width-1:0] gs [levels+1];
			logic [width-1:0] ps [levels+1];

			assign gs[0] = gi;
			assign ps[0] = pi;

			for (genvar l = 0; l < levels; l++) begin : g_level
				for (genvar i = 0; i < width; i++) begin : g_bit
					if (((i >> l) & 1) == 1) begin : g_node
						// top bit of the lower half block, shared by the whole upper half
						localparam int j = ((i >> l) << l) - 1;
						assign gs[l+1][i] = gs[l][i] | (ps[l][i] & gs[l][j]);
						assign ps[l+1][i] = ps[l][i] & ps[l][j];
					end else begin : g_pass
						assign gs[l+1][i] = gs[l][i];
						assign ps[l+1][i] = ps[l][i];
					end
				end
			end

			assign go = gs[levels];
			assign po = ps[levels];
		end
	endgenerate

endmodule

// File: hdl/lau_pkg.sv
// shared types of the subtraction unit
// prefix network variant and operation codes

package lau_pkg;

	// prefix network variant, trades depth against area
	// SLOW serial ripple chain, smallest area
	// MEDIUM Brent-Kung tree, about 2*log2(width) levels
	// FAST Sklansky tree, log2(width) levels with high fanout
	typedef enum logic [1:0] {
		SLOW   = 2'd0,
		MEDIUM = 2'd1,
		FAST   = 2'd2
	} speed_e;

	// operation code carried with each op_valid strobe
	// OP_SUB plain subtract, borrow-in forced to 0
	// OP_SBB subtract with the borrow kept from the last operation
	//   used for the upper words of a wide subtraction
	// OP_CMP flags only, result register is left alone
	// OP_NOP reserved, the unit ignores it
	typedef enum logic [1:0] {
		OP_SUB = 2'b00,
		OP_SBB = 2'b01,
		OP_CMP = 2'b10,
		OP_NOP = 2'b11
	} sub_op_e;

endpackage

// File: include/lau_config.svh
`ifndef LAU_CONFIG_SVH
`define LAU_CONFIG_SVH

// default configuration of the subtraction unit

// word width in bits, any value of 2 or more works
`define LAU_WIDTH 16

// prefix network variant, one of SLOW, MEDIUM or FAST from lau_pkg
// the including module brings lau_pkg in by wildcard import
`define LAU_SPEED FAST

`endif
